// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mpu_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(BUILD_DIR)

// File: logic/mpu_access_pkg.sv
package mpu_access_pkg;

    // kind of access being checked.
    typedef enum logic [1:0] {
        READ  = 2'd0,
        WRITE = 2'd1,
        EXEC  = 2'd2
    } access_e;

    // privilege of the requester.
    typedef enum logic [1:0] {
        USER    = 2'd0,
        MACHINE = 2'd3
    } priv_e;

endpackage

// File: logic/mpu_cfg_pkg.sv
package mpu_cfg_pkg;

    // address-match mode of an entry.
    typedef enum logic [1:0] {
        OFF   = 2'd0,
        TOR   = 2'd1,
        NA4   = 2'd2,
        NAPOT = 2'd3
    } addr_mode_e;

    // protection view of a configuration byte.
    typedef struct packed {
        logic       l;
        logic [1:0] rsvd;
        addr_mode_e a;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_t;

    // attribute view, e marks a region where every access faults.
    typedef struct packed {
        logic       l;
        logic [1:0] rsvd;
        addr_mode_e a;
        logic       rsvd_x;
        logic       c;
        logic       e;
    } pma_cfg_t;

    typedef union packed {
        pmp_cfg_t pmp;
        pma_cfg_t pma;
    } cfg_entry_u;

endpackage

// File: logic/mpu_check.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_check (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               chk_valid,
    input  mpu_access_pkg::access_e            chk_type,
    input  mpu_access_pkg::priv_e              chk_priv,
    input  logic                               pmp_hit,
    input  logic [$clog2(`PMP_ENTRIES)-1:0]    pmp_idx,
    input  mpu_cfg_pkg::cfg_entry_u            pmp_cfg [`PMP_ENTRIES],
    input  logic                               pma_hit,
    input  logic [$clog2(`PMA_ENTRIES)-1:0]    pma_idx,
    input  mpu_cfg_pkg::cfg_entry_u            pma_cfg [`PMA_ENTRIES],
    output logic                               res_valid,
    output logic                               res_fault,
    output logic                               res_cacheable
);

    mpu_cfg_pkg::cfg_entry_u pmp_ent;
    mpu_cfg_pkg::cfg_entry_u pma_ent;
    logic                    is_user;
    logic                    perm;
    logic                    pmp_fault;
    logic                    fault;
    logic                    cacheable;

    assign pmp_ent = pmp_cfg[pmp_idx];
    assign pma_ent = pma_cfg[pma_idx];
    assign is_user = (chk_priv != mpu_access_pkg::MACHINE);

    always_comb begin
        case (chk_type)
            mpu_access_pkg::READ:  perm = pmp_ent.pmp.r;
            mpu_access_pkg::WRITE: perm = pmp_ent.pmp.w;
            mpu_access_pkg::EXEC:  perm = pmp_ent.pmp.x;
            default:               perm = 1'b0;
        endcase
    end

    // machine mode is only bound by locked entries and passes on a miss.
    always_comb begin
        if (pmp_hit && (is_user || pmp_ent.pmp.l)) begin
            pmp_fault = !perm;
        end else begin
            pmp_fault = !pmp_hit && is_user;
        end
    end

    assign fault     = pmp_fault || (pma_hit && pma_ent.pma.e);
    assign cacheable = pma_hit && pma_ent.pma.c;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid     <= 1'b0;
            res_fault     <= 1'b0;
            res_cacheable <= 1'b0;
        end else begin
            res_valid     <= chk_valid;
            res_fault     <= chk_valid && fault;
            res_cacheable <= chk_valid && cacheable;
        end
    end

endmodule

// File: logic/mpu_csr.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_csr (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    csr_wr,
    input  logic [11:0]             csr_waddr,
    input  logic [`XLEN-1:0]        csr_wdata,
    input  logic [11:0]             csr_raddr,
    output logic [`XLEN-1:0]        csr_rdata,
    output mpu_cfg_pkg::cfg_entry_u pmp_cfg  [`PMP_ENTRIES],
    output logic [`PADDR_LEN-3:0]   pmp_addr [`PMP_ENTRIES],
    output mpu_cfg_pkg::cfg_entry_u pma_cfg  [`PMA_ENTRIES],
    output logic [`PADDR_LEN-3:0]   pma_addr [`PMA_ENTRIES]
);

    logic [`PMP_ENTRIES-1:0] pmp_addr_lock;
    logic [`PMA_ENTRIES-1:0] pma_addr_lock;

    // cfg register that holds entry idx.
    function automatic logic [11:0] cfg_csr(input logic [11:0] base, input int idx);
        return 12'(base + idx / `CFG_PER_CSR);
    endfunction

    // w without r is not a legal combination.
    function automatic mpu_cfg_pkg::cfg_entry_u pmp_legal(input logic [7:0] b);
        mpu_cfg_pkg::cfg_entry_u v;
        v = b;
        v.pmp.rsvd = 2'b00;
        v.pmp.w = v.pmp.w & v.pmp.r;
        return v;
    endfunction

    function automatic mpu_cfg_pkg::cfg_entry_u pma_legal(input logic [7:0] b);
        mpu_cfg_pkg::cfg_entry_u v;
        v = b;
        v.pma.rsvd = 2'b00;
        v.pma.rsvd_x = 1'b0;
        return v;
    endfunction

    // entry 0 covers the cacheable low memory, entry 1 the uncached io space above it.
    function automatic mpu_cfg_pkg::cfg_entry_u pma_rst_cfg(input int idx);
        mpu_cfg_pkg::cfg_entry_u v;
        v = '0;
        if (idx < 2) begin
            v.pma.l = 1'b1;
            v.pma.a = mpu_cfg_pkg::TOR;
            v.pma.c = (idx == 0);
        end
        return v;
    endfunction

    function automatic logic [`PADDR_LEN-3:0] pma_rst_addr(input int idx);
        case (idx)
            0:       return (`PADDR_LEN-2)'('h0100_0000);
            1:       return (`PADDR_LEN-2)'('h1000_0000);
            default: return '0;
        endcase
    endfunction

    // an address is frozen by its own lock or by a locked tor entry above it.
    for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_pmp_lock
        if (i < `PMP_ENTRIES - 1) begin : g_mid
            assign pmp_addr_lock[i] = pmp_cfg[i].pmp.l |
                (pmp_cfg[i+1].pmp.l & (pmp_cfg[i+1].pmp.a == mpu_cfg_pkg::TOR));
        end else begin : g_last
            assign pmp_addr_lock[i] = pmp_cfg[i].pmp.l;
        end
    end

    for (genvar i = 0; i < `PMA_ENTRIES; i++) begin : g_pma_lock
        if (i < `PMA_ENTRIES - 1) begin : g_mid
            assign pma_addr_lock[i] = pma_cfg[i].pma.l |
                (pma_cfg[i+1].pma.l & (pma_cfg[i+1].pma.a == mpu_cfg_pkg::TOR));
        end else begin : g_last
            assign pma_addr_lock[i] = pma_cfg[i].pma.l;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                pmp_cfg[i]  <= '0;
                pmp_addr[i] <= '0;
            end
        end else if (csr_wr) begin
            for (int i = 0; i < `PMP_ENTRIES; i++) begin
                if (csr_waddr == cfg_csr(`CSR_PMPCFG0_ADDR, i) && !pmp_cfg[i].pmp.l) begin
                    pmp_cfg[i] <= pmp_legal(csr_wdata[(i % `CFG_PER_CSR)*8 +: 8]);
                end
                if (csr_waddr == 12'(`CSR_PMPADDR0_ADDR + i) && !pmp_addr_lock[i]) begin
                    pmp_addr[i] <= csr_wdata[`PADDR_LEN-3:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `PMA_ENTRIES; i++) begin
                pma_cfg[i]  <= pma_rst_cfg(i);
                pma_addr[i] <= pma_rst_addr(i);
            end
        end else if (csr_wr) begin
            for (int i = 0; i < `PMA_ENTRIES; i++) begin
                if (csr_waddr == cfg_csr(`CSR_PMACFG0_ADDR, i) && !pma_cfg[i].pma.l) begin
                    pma_cfg[i] <= pma_legal(csr_wdata[(i % `CFG_PER_CSR)*8 +: 8]);
                end
                if (csr_waddr == 12'(`CSR_PMAADDR0_ADDR + i) && !pma_addr_lock[i]) begin
                    pma_addr[i] <= csr_wdata[`PADDR_LEN-3:0];
                end
            end
        end
    end

    // unimplemented registers fall through to zero.
    always_comb begin
        csr_rdata = '0;
        for (int i = 0; i < `PMP_ENTRIES; i++) begin
            if (csr_raddr == cfg_csr(`CSR_PMPCFG0_ADDR, i)) begin
                csr_rdata[(i % `CFG_PER_CSR)*8 +: 8] = pmp_cfg[i];
            end
            if (csr_raddr == 12'(`CSR_PMPADDR0_ADDR + i)) begin
                csr_rdata = `XLEN'(pmp_addr[i]);
            end
        end
        for (int i = 0; i < `PMA_ENTRIES; i++) begin
            if (csr_raddr == cfg_csr(`CSR_PMACFG0_ADDR, i)) begin
                csr_rdata[(i % `CFG_PER_CSR)*8 +: 8] = pma_cfg[i];
            end
            if (csr_raddr == 12'(`CSR_PMAADDR0_ADDR + i)) begin
                csr_rdata = `XLEN'(pma_addr[i]);
            end
        end
    end

endmodule

// File: logic/mpu_defs.svh
`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

// data and physical address widths.
`define XLEN        32
`define PADDR_LEN   34

// table sizes.
`define PMP_ENTRIES 4'd8
`define PMA_ENTRIES 4'd4

// configuration bytes held by one cfg register.
`define CFG_PER_CSR 4

// pmp csr map.
`define CSR_PMPCFG0_ADDR  12'h3A0
`define CSR_PMPCFG1_ADDR  12'h3A1
`define CSR_PMPCFG2_ADDR  12'h3A2
`define CSR_PMPCFG3_ADDR  12'h3A3
`define CSR_PMPADDR0_ADDR 12'h3B0

// pma csr map.
`define CSR_PMACFG0_ADDR  12'h3C0
`define CSR_PMACFG1_ADDR  12'h3C1
`define CSR_PMACFG2_ADDR  12'h3C2
`define CSR_PMACFG3_ADDR  12'h3C3
`define CSR_PMAADDR0_ADDR 12'h3D0

`endif

// File: logic/mpu_region_match.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_region_match #(
    parameter int ENTRIES = 8
) (
    input  mpu_cfg_pkg::cfg_entry_u      cfg      [ENTRIES],
    input  logic [`PADDR_LEN-3:0]        addr_tab [ENTRIES],
    input  logic [`PADDR_LEN-1:0]        addr,
    output logic                         hit,
    output logic [$clog2(ENTRIES)-1:0]   idx
);

    localparam int IW = $clog2(ENTRIES);

    logic [`PADDR_LEN-3:0] word;
    logic [ENTRIES-1:0]    match;

    assign word = addr[`PADDR_LEN-1:2];

    for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
        logic [`PADDR_LEN-3:0] base;
        logic [`PADDR_LEN-3:0] napot_mask;

        // tor starts where the entry below ends.
        if (i == 0) begin : g_first
            assign base = '0;
        end else begin : g_rest
            assign base = addr_tab[i-1];
        end

        // trailing ones plus the first zero give the don't-care bits.
        assign napot_mask = addr_tab[i] ^ (addr_tab[i] + 1'b1);

        // the a field sits at the same place in both views.
        always_comb begin
            case (cfg[i].pmp.a)
                mpu_cfg_pkg::TOR:   match[i] = (word >= base) && (word < addr_tab[i]);
                mpu_cfg_pkg::NA4:   match[i] = (word == addr_tab[i]);
                mpu_cfg_pkg::NAPOT: match[i] = ((word ^ addr_tab[i]) & ~napot_mask) == '0;
                default:            match[i] = 1'b0;
            endcase
        end
    end

    // scan from the top so the lowest matching entry is left.
    always_comb begin
        hit = 1'b0;
        idx = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit = 1'b1;
                idx = IW'(i);
            end
        end
    end

endmodule

// File: logic/mpu_top.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    csr_wr,
    input  logic [11:0]             csr_waddr,
    input  logic [`XLEN-1:0]        csr_wdata,
    input  logic [11:0]             csr_raddr,
    output logic [`XLEN-1:0]        csr_rdata,
    input  logic                    chk_valid,
    input  logic [`PADDR_LEN-1:0]   chk_addr,
    input  mpu_access_pkg::access_e chk_type,
    input  mpu_access_pkg::priv_e   chk_priv,
    output logic                    res_valid,
    output logic                    res_fault,
    output logic                    res_cacheable
);

    mpu_cfg_pkg::cfg_entry_u             pmp_cfg  [`PMP_ENTRIES];
    logic [`PADDR_LEN-3:0]               pmp_addr [`PMP_ENTRIES];
    mpu_cfg_pkg::cfg_entry_u             pma_cfg  [`PMA_ENTRIES];
    logic [`PADDR_LEN-3:0]               pma_addr [`PMA_ENTRIES];
    logic                                pmp_hit;
    logic [$clog2(`PMP_ENTRIES)-1:0]     pmp_idx;
    logic                                pma_hit;
    logic [$clog2(`PMA_ENTRIES)-1:0]     pma_idx;

    mpu_csr csr0 (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata),
        .pmp_cfg   (pmp_cfg),
        .pmp_addr  (pmp_addr),
        .pma_cfg   (pma_cfg),
        .pma_addr  (pma_addr)
    );

    // the tables feed the matchers directly, so a write applies from the next cycle.
    mpu_region_match #(.ENTRIES(`PMP_ENTRIES)) pmp_match (
        .cfg      (pmp_cfg),
        .addr_tab (pmp_addr),
        .addr     (chk_addr),
        .hit      (pmp_hit),
        .idx      (pmp_idx)
    );

    mpu_region_match #(.ENTRIES(`PMA_ENTRIES)) pma_match (
        .cfg      (pma_cfg),
        .addr_tab (pma_addr),
        .addr     (chk_addr),
        .hit      (pma_hit),
        .idx      (pma_idx)
    );

    mpu_check check0 (
        .clk           (clk),
        .rstn          (rstn),
        .chk_valid     (chk_valid),
        .chk_type      (chk_type),
        .chk_priv      (chk_priv),
        .pmp_hit       (pmp_hit),
        .pmp_idx       (pmp_idx),
        .pmp_cfg       (pmp_cfg),
        .pma_hit       (pma_hit),
        .pma_idx       (pma_idx),
        .pma_cfg       (pma_cfg),
        .res_valid     (res_valid),
        .res_fault     (res_fault),
        .res_cacheable (res_cacheable)
    );

endmodule

// File: sources.f
+incdir+logic
logic/mpu_cfg_pkg.sv
logic/mpu_access_pkg.sv
logic/mpu_csr.sv
logic/mpu_region_match.sv
logic/mpu_check.sv
logic/mpu_top.sv
tests/mpu_chk.sv
tests/mpu_tb.sv

// File: tests/mpu_chk.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_chk (
    input logic             clk,
    input logic             rstn,
    input logic             chk_valid,
    input logic             res_valid,
    input logic [11:0]      csr_raddr,
    input logic [`XLEN-1:0] csr_rdata
);

    // one result per request, exactly one cycle later.
    valid_follows: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(rstn) |-> (res_valid == $past(chk_valid))
    ) else $error("res_valid does not follow chk_valid by one cycle");

    no_valid_in_reset: assert property (
        @(posedge clk) !$past(rstn) |-> !res_valid
    ) else $error("res_valid high during or right after reset");

    // w sits one bit above r in every byte.
    cfg_w_needs_r: assert property (
        @(posedge clk) disable iff (!rstn)
        (csr_raddr == `CSR_PMPCFG0_ADDR) |->
            (((csr_rdata >> 1) & ~csr_rdata & 32'h0101_0101) == '0)
    ) else $error("pmpcfg0 reads back w set with r clear");

endmodule

// File: tests/mpu_tb.sv
`timescale 1ns/1ps
`include "mpu_defs.svh"

module mpu_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NPMP         = `PMP_ENTRIES;
    localparam int NPMA         = `PMA_ENTRIES;
    localparam int N_RANDOM     = 300;
    // three full register sweeps, the writes and the directed requests.
    localparam int N_OPS        = N_RANDOM + N_RANDOM / 4 + 200;
    localparam logic [31:0] ADDR_MASK = 32'((64'd1 << (`PADDR_LEN - 2)) - 64'd1);

    logic                    clk;
    logic                    rstn;
    logic                    csr_wr;
    logic [11:0]             csr_waddr;
    logic [`XLEN-1:0]        csr_wdata;
    logic [11:0]             csr_raddr;
    logic [`XLEN-1:0]        csr_rdata;
    logic                    chk_valid;
    logic [`PADDR_LEN-1:0]   chk_addr;
    mpu_access_pkg::access_e chk_type;
    mpu_access_pkg::priv_e   chk_priv;
    logic                    res_valid;
    logic                    res_fault;
    logic                    res_cacheable;

    // expected table contents that track every csr write.
    logic [7:0]  pmp_c [NPMP];
    logic [31:0] pmp_a [NPMP];
    logic [7:0]  pma_c [NPMA];
    logic [31:0] pma_a [NPMA];

    int errors;
    int checks;

    mpu_top dut0 (
        .clk           (clk),
        .rstn          (rstn),
        .csr_wr        (csr_wr),
        .csr_waddr     (csr_waddr),
        .csr_wdata     (csr_wdata),
        .csr_raddr     (csr_raddr),
        .csr_rdata     (csr_rdata),
        .chk_valid     (chk_valid),
        .chk_addr      (chk_addr),
        .chk_type      (chk_type),
        .chk_priv      (chk_priv),
        .res_valid     (res_valid),
        .res_fault     (res_fault),
        .res_cacheable (res_cacheable)
    );

    bind mpu_top mpu_chk chk0 (
        .clk       (clk),
        .rstn      (rstn),
        .chk_valid (chk_valid),
        .res_valid (res_valid),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 2 * N_OPS + 10));
        $display("ERROR: the run did not finish in time, %0d errors so far", errors);
        $display("** FAIL **");
        $finish;
    end

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // a mode 1 to 3 entry against the word address; lo is the address of the entry below.
    function automatic logic entry_hits(input logic [1:0] mode, input logic [31:0] word,
                                        input logic [31:0] lo, input logic [31:0] top);
        int t;
        t = 0;
        case (mode)
            2'd1: return (word >= lo) && (word < top);
            2'd2: return word == top;
            2'd3: begin
                while (t < 32 && top[t]) begin
                    t++;
                end
                return (word >> (t + 1)) == (top >> (t + 1));
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic grants(input logic [7:0] c, input mpu_access_pkg::access_e k);
        case (k)
            mpu_access_pkg::READ:  return c[0];
            mpu_access_pkg::WRITE: return c[1];
            default:               return c[2];
        endcase
    endfunction

    function automatic mpu_access_pkg::access_e random_kind();
        case ($urandom_range(2, 0))
            0:       return mpu_access_pkg::READ;
            1:       return mpu_access_pkg::WRITE;
            default: return mpu_access_pkg::EXEC;
        endcase
    endfunction

    function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
        logic [7:0] b;
        logic       lock;
        int         e;
        for (int i = 0; i < 4; i++) begin
            b = d[i*8 +: 8];
            b[6:5] = 2'b00;
            if (a == `CSR_PMPCFG0_ADDR || a == `CSR_PMPCFG1_ADDR) begin
                e = (a == `CSR_PMPCFG1_ADDR) ? i + 4 : i;
                b[1] = b[1] & b[0];
                if (!pmp_c[e][7]) begin
                    pmp_c[e] = b;
                end
            end
            if (a == `CSR_PMACFG0_ADDR && !pma_c[i][7]) begin
                b[2] = 1'b0;
                pma_c[i] = b;
            end
        end
        for (int i = 0; i < NPMP; i++) begin
            lock = pmp_c[i][7];
            if (i + 1 < NPMP) begin
                lock = lock || (pmp_c[(i + 1) % NPMP][7] && pmp_c[(i + 1) % NPMP][4:3] == 2'b01);
            end
            if (a == 12'(`CSR_PMPADDR0_ADDR + i) && !lock) begin
                pmp_a[i] = d & ADDR_MASK;
            end
        end
        for (int i = 0; i < NPMA; i++) begin
            lock = pma_c[i][7];
            if (i + 1 < NPMA) begin
                lock = lock || (pma_c[(i + 1) % NPMA][7] && pma_c[(i + 1) % NPMA][4:3] == 2'b01);
            end
            if (a == 12'(`CSR_PMAADDR0_ADDR + i) && !lock) begin
                pma_a[i] = d & ADDR_MASK;
            end
        end
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        logic [31:0] v;
        v = '0;
        if (a == `CSR_PMPCFG0_ADDR) v = {pmp_c[3], pmp_c[2], pmp_c[1], pmp_c[0]};
        if (a == `CSR_PMPCFG1_ADDR) v = {pmp_c[7], pmp_c[6], pmp_c[5], pmp_c[4]};
        if (a == `CSR_PMACFG0_ADDR) v = {pma_c[3], pma_c[2], pma_c[1], pma_c[0]};
        for (int i = 0; i < NPMP; i++) begin
            if (a == 12'(`CSR_PMPADDR0_ADDR + i)) v = pmp_a[i];
        end
        for (int i = 0; i < NPMA; i++) begin
            if (a == 12'(`CSR_PMAADDR0_ADDR + i)) v = pma_a[i];
        end
        return v;
    endfunction

    task automatic csr_write(input logic [11:0] a, input logic [`XLEN-1:0] d);
        model_write(a, d);
        csr_wr    = 1'b1;
        csr_waddr = a;
        csr_wdata = d;
        @(posedge clk);
        #1;
        csr_wr = 1'b0;
    endtask

    task automatic read_expect(input logic [11:0] a, input logic [`XLEN-1:0] exp);
        csr_raddr = a;
        @(posedge clk);
        #1;
        expect_eq($sformatf("csr_rdata[%h]", a), csr_rdata, exp);
    endtask

    // sweeps both cfg ranges and both address ranges including unimplemented ones.
    task automatic read_all();
        for (int i = 0; i < 4; i++) begin
            read_expect(12'(`CSR_PMPCFG0_ADDR + i), model_read(12'(`CSR_PMPCFG0_ADDR + i)));
            read_expect(12'(`CSR_PMACFG0_ADDR + i), model_read(12'(`CSR_PMACFG0_ADDR + i)));
        end
        for (int i = 0; i < 16; i++) begin
            read_expect(12'(`CSR_PMPADDR0_ADDR + i), model_read(12'(`CSR_PMPADDR0_ADDR + i)));
            read_expect(12'(`CSR_PMAADDR0_ADDR + i), model_read(12'(`CSR_PMAADDR0_ADDR + i)));
        end
    endtask

    task automatic request(input logic [`PADDR_LEN-1:0] a, input mpu_access_pkg::access_e k,
                           input mpu_access_pkg::priv_e p);
        logic [31:0] word;
        logic [31:0] lo;
        logic        user;
        logic        found;
        logic        exp_fault;
        logic        exp_cache;
        word      = a[`PADDR_LEN-1:2];
        user      = (p == mpu_access_pkg::USER);
        exp_fault = user;
        exp_cache = 1'b0;
        found     = 1'b0;
        lo        = '0;
        for (int i = 0; i < NPMP; i++) begin
            if (!found && entry_hits(pmp_c[i][4:3], word, lo, pmp_a[i])) begin
                found = 1'b1;
                // an unlocked entry leaves machine mode alone.
                exp_fault = (user || pmp_c[i][7]) ? !grants(pmp_c[i], k) : 1'b0;
            end
            lo = pmp_a[i];
        end
        found = 1'b0;
        lo    = '0;
        for (int i = 0; i < NPMA; i++) begin
            if (!found && entry_hits(pma_c[i][4:3], word, lo, pma_a[i])) begin
                found     = 1'b1;
                exp_fault = exp_fault | pma_c[i][0];
                exp_cache = pma_c[i][1];
            end
            lo = pma_a[i];
        end
        chk_valid = 1'b1;
        chk_addr  = a;
        chk_type  = k;
        chk_priv  = p;
        @(posedge clk);
        #1;
        chk_valid = 1'b0;
        expect_eq($sformatf("res_valid @%h", a), 32'(res_valid), 32'd1);
        expect_eq($sformatf("res_fault @%h", a), 32'(res_fault), 32'(exp_fault));
        expect_eq($sformatf("res_cacheable @%h", a), 32'(res_cacheable), 32'(exp_cache));
    endtask

    initial begin
        void'($urandom(32'h3104));
        errors    = 0;
        checks    = 0;
        rstn      = 1'b0;
        csr_wr    = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        csr_raddr = '0;
        // requests held during reset must not produce results.
        chk_valid = 1'b1;
        chk_addr  = '0;
        chk_type  = mpu_access_pkg::READ;
        chk_priv  = mpu_access_pkg::MACHINE;
        for (int i = 0; i < NPMP; i++) begin
            pmp_c[i] = '0;
            pmp_a[i] = '0;
        end
        for (int i = 0; i < NPMA; i++) begin
            pma_c[i] = '0;
            pma_a[i] = '0;
        end
        // locked tor, cacheable low memory and the uncached space above it.
        pma_c[0] = 8'h8A;
        pma_a[0] = 32'h0100_0000;
        pma_c[1] = 8'h88;
        pma_a[1] = 32'h1000_0000;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn      = 1'b1;
        chk_valid = 1'b0;
        @(posedge clk);
        #1;

        read_all();
        request(34'h0000_1000, mpu_access_pkg::READ, mpu_access_pkg::MACHINE);
        request(34'h0000_1000, mpu_access_pkg::READ, mpu_access_pkg::USER);

        // w without r and reserved bits in both cfg registers, then the unimplemented registers.
        csr_write(`CSR_PMPCFG0_ADDR, 32'h0A02_6A06);
        csr_write(`CSR_PMPCFG1_ADDR, 32'h6002_0600);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 5), 32'hFFFF_FFFF);
        csr_write(`CSR_PMPCFG2_ADDR, 32'h1F1F_1F1F);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 12), 32'h1234_5678);
        csr_write(`CSR_PMACFG1_ADDR, 32'h1F1F_1F1F);
        read_expect(`CSR_PMPCFG0_ADDR, 32'h0800_0804);
        read_expect(`CSR_PMPCFG1_ADDR, 32'h0000_0400);
        read_all();

        // na4 x-only inside a tor rx range, then a napot rw block above it.
        csr_write(12'(`CSR_PMPADDR0_ADDR + 0), 32'h0000_0500);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 1), 32'h0000_0400);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 2), 32'h0000_0800);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 3), 32'h0000_0BFF);
        csr_write(`CSR_PMPCFG0_ADDR, 32'h1B0D_0014);
        request(34'h0000_1400, mpu_access_pkg::EXEC, mpu_access_pkg::USER);
        request(34'h0000_1400, mpu_access_pkg::READ, mpu_access_pkg::USER);
        request(34'h0000_1404, mpu_access_pkg::READ, mpu_access_pkg::USER);
        request(34'h0000_1404, mpu_access_pkg::WRITE, mpu_access_pkg::USER);
        request(34'h0000_2000, mpu_access_pkg::WRITE, mpu_access_pkg::USER);
        request(34'h0000_3FFC, mpu_access_pkg::EXEC, mpu_access_pkg::USER);
        request(34'h0000_4000, mpu_access_pkg::READ, mpu_access_pkg::USER);
        for (int n = 0; n < N_RANDOM; n++) begin
            request(34'($urandom_range(32'h47FF, 32'h0C00)), random_kind(), mpu_access_pkg::USER);
        end

        request(34'h0000_1400, mpu_access_pkg::WRITE, mpu_access_pkg::MACHINE);
        csr_write(`CSR_PMPCFG0_ADDR, 32'h1B0D_0094);
        request(34'h0000_1400, mpu_access_pkg::WRITE, mpu_access_pkg::MACHINE);
        request(34'h0000_1400, mpu_access_pkg::EXEC, mpu_access_pkg::MACHINE);

        // entry 0 stays locked, entry 2 becomes locked tor and freezes address 1.
        csr_write(`CSR_PMPCFG0_ADDR, 32'h008D_0000);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 0), 32'h0000_0777);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 1), 32'h0000_0777);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 3), 32'h0000_0123);
        csr_write(`CSR_PMPCFG0_ADDR, 32'hFFFF_FFFF);
        csr_write(12'(`CSR_PMPADDR0_ADDR + 3), 32'h0000_0055);
        csr_write(`CSR_PMACFG0_ADDR, 32'h0000_0000);
        csr_write(12'(`CSR_PMAADDR0_ADDR + 0), 32'h0000_0005);
        csr_write(12'(`CSR_PMAADDR0_ADDR + 1), 32'h0000_0006);
        read_all();

        // pma entry 2 covers 0x8000_0000 to 0x8000_ffff.
        csr_write(12'(`CSR_PMAADDR0_ADDR + 2), 32'h2000_1FFF);
        csr_write(`CSR_PMACFG0_ADDR, 32'h0019_0000);
        request(34'h0_8000_0100, mpu_access_pkg::READ, mpu_access_pkg::MACHINE);
        request(34'h0_8000_FFFC, mpu_access_pkg::EXEC, mpu_access_pkg::MACHINE);
        request(34'h0_8001_0000, mpu_access_pkg::READ, mpu_access_pkg::MACHINE);
        csr_write(`CSR_PMACFG0_ADDR, 32'h001A_0000);
        request(34'h0_8000_0040, mpu_access_pkg::WRITE, mpu_access_pkg::MACHINE);
        request(34'h0_0500_0000, mpu_access_pkg::READ, mpu_access_pkg::MACHINE);
        request(34'h0_0000_0100, mpu_access_pkg::READ, mpu_access_pkg::MACHINE);
        request(34'h0_8000_0800, mpu_access_pkg::EXEC, mpu_access_pkg::USER);
        for (int n = 0; n < N_RANDOM / 4; n++) begin
            request(34'($urandom_range(32'h47FF, 32'h0C00)), random_kind(),
                    ($urandom_range(1, 0) == 0) ? mpu_access_pkg::USER : mpu_access_pkg::MACHINE);
        end

        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
